//--- design/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // Eight-byte lines and 16 of them. The rest of the counter is tag.
  localparam int offset_bits = 3;
  localparam int index_bits = 4;
  localparam int tag_bits = 32 - index_bits - offset_bits;
  localparam int line_count = 2 ** index_bits;

  localparam logic [31:0] reset_pc = 32'h3000_0000; // Boot address.

  // Top address byte of the on-chip SRAM, which bypasses the cache.
  localparam logic [7:0] uncached_region = 8'h0f;

  // One cache line as stored in the array.
  typedef struct packed {
    logic                valid;
    logic [tag_bits-1:0] tag;
    logic [31:0]         word_high; // Word at line address + 4.
    logic [31:0]         word_low;  // Word at line address.
  } cache_line_t;

  // Result of a lookup for the current counter.
  typedef struct packed {
    logic        hit;
    logic [31:0] word; // Selected by counter bit 2.
  } lookup_t;

endpackage

`default_nettype wire

//--- design/bus_pkg.sv
`default_nettype none

package bus_pkg;

  // Read response codes of the burst bus.
  typedef enum logic [1:0] {
    okay   = 2'b00,
    exokay = 2'b01,
    slverr = 2'b10,
    decerr = 2'b11
  } resp_code_e;

  // Address channel from master to slave.
  typedef struct packed {
    logic        arvalid;
    logic [31:0] araddr; // Always line aligned.
  } read_request_t;

  // Data channel from slave to master. Two beats per burst, low word first.
  typedef struct packed {
    logic        rvalid;
    logic        rlast;
    resp_code_e  rresp;
    logic [31:0] rdata;
  } read_response_t;

endpackage

`default_nettype wire

//--- design/icache_store.sv
`timescale 1ns/1ps
`default_nettype none

module icache_store (
  input  logic                  clock,
  input  logic                  reset,
  input  logic [31:0]           pc,
  output fetch_pkg::lookup_t    lookup,
  input  logic                  fill_valid,
  input  logic [31:0]           fill_addr,
  input  fetch_pkg::cache_line_t fill_line,
  input  logic                  flush
);

  fetch_pkg::cache_line_t lines [fetch_pkg::line_count];

  logic [fetch_pkg::index_bits-1:0] pc_index;
  logic [fetch_pkg::tag_bits-1:0]   pc_tag;
  logic [fetch_pkg::index_bits-1:0] fill_index;
  fetch_pkg::cache_line_t           entry;

  // Counter split into tag, index and byte offset.
  assign pc_index = pc[fetch_pkg::offset_bits +: fetch_pkg::index_bits];
  assign pc_tag = pc[31 -: fetch_pkg::tag_bits];
  assign fill_index = fill_addr[fetch_pkg::offset_bits +: fetch_pkg::index_bits];

  assign entry = lines[pc_index];

  // Lookup is purely combinational.
  always_comb begin
    lookup.hit = entry.valid && (entry.tag == pc_tag);
    if (pc[fetch_pkg::offset_bits-1]) begin
      lookup.word = entry.word_high;
    end else begin
      lookup.word = entry.word_low;
    end
  end

  // Flush wins over a fill in the same cycle.
  always_ff @(posedge clock) begin
    if (reset || flush) begin
      for (int i = 0; i < fetch_pkg::line_count; i++) begin
        lines[i].valid <= 1'b0;
      end
    end else if (fill_valid) begin
      lines[fill_index] <= fill_line;
    end
  end

endmodule

`default_nettype wire

//--- design/fetch_control.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_control (
  input  logic                    clock,
  input  logic                    reset,

  input  logic                    redirect,
  input  logic [31:0]             redirect_pc,
  input  logic                    npc_valid,
  input  logic [31:0]             snpc,

  output logic [31:0]             pc,
  input  fetch_pkg::lookup_t      lookup,
  output logic                    fill_valid,
  output logic [31:0]             fill_addr,
  output fetch_pkg::cache_line_t  fill_line,

  output logic                    inst_valid,
  output logic [31:0]             inst,
  output logic [31:0]             old_pc,
  input  logic                    idu_ready,
  input  logic                    block,

  output bus_pkg::read_request_t  request,
  input  logic                    arready,
  input  bus_pkg::read_response_t response,
  output logic                    rready
);

  typedef enum logic [1:0] {
    lookup_state,
    await_address,
    await_data
  } fetch_state_e;

  fetch_state_e state;

  logic        permit;       // Counter is known to be on the real path.
  logic        drop;         // Burst in flight belongs to a discarded fetch.
  logic        arvalid;
  logic [31:0] line_address;
  logic [31:0] first_word;   // Low word of the burst.

  logic fetch_enable;
  logic uncached;
  logic hit;
  logic may_issue;
  logic hit_take;
  logic miss_issue;
  logic beat;
  logic last_beat;
  logic deliver;

  assign fetch_enable = idu_ready && !block;
  assign uncached = (pc[31:24] == fetch_pkg::uncached_region);
  assign hit = lookup.hit && !uncached; // SRAM always goes to the bus.

  // Only fetch from memory when the counter cannot be a wrong-path guess.
  assign may_issue = permit || (npc_valid && (snpc == pc));

  assign hit_take = (state == lookup_state) && fetch_enable && !redirect && hit;
  assign miss_issue = (state == lookup_state) && fetch_enable && !redirect && !hit && may_issue;

  assign beat = (state == await_data) && rready && response.rvalid;
  assign last_beat = beat && response.rlast;
  assign deliver = last_beat && !drop && !redirect;

  // Fill is written at the edge that takes the last beat.
  assign fill_valid = deliver && (line_address[31:24] != fetch_pkg::uncached_region);
  assign fill_addr = line_address;
  assign fill_line.valid = 1'b1;
  assign fill_line.tag = line_address[31 -: fetch_pkg::tag_bits];
  assign fill_line.word_high = response.rdata;
  assign fill_line.word_low = first_word;

  assign request.arvalid = arvalid;
  assign request.araddr = line_address;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= fetch_pkg::reset_pc;
      state <= lookup_state;
      permit <= 1'b1;
      drop <= 1'b0;
      arvalid <= 1'b0;
      rready <= 1'b0;
      inst_valid <= 1'b0;
    end else begin
      if (redirect) begin
        pc <= redirect_pc;
        permit <= 1'b1;
        inst_valid <= 1'b0;
        if (state != lookup_state) begin
          drop <= 1'b1; // Let the burst finish, then throw it away.
        end
      end else if (state == lookup_state && fetch_enable) begin
        if (hit) begin
          inst_valid <= 1'b1;
          pc <= pc + 32'd4;
          permit <= 1'b0;
        end else begin
          inst_valid <= 1'b0;
          if (may_issue) begin
            state <= await_address;
            arvalid <= 1'b1;
            permit <= 1'b0;
          end
        end
      end

      case (state)
        await_address: begin
          if (arready) begin
            arvalid <= 1'b0;
            rready <= 1'b1;
            state <= await_data;
          end
        end
        await_data: begin
          if (last_beat) begin
            rready <= 1'b0;
            drop <= 1'b0;
            state <= lookup_state;
            if (deliver) begin
              inst_valid <= 1'b1;
              pc <= pc + 32'd4;
            end
          end
        end
        default: begin
        end
      endcase
    end
  end

  // Instruction and burst payload.
  always_ff @(posedge clock) begin
    if (hit_take) begin
      inst <= lookup.word;
      old_pc <= pc;
    end
    if (miss_issue) begin
      line_address <= {pc[31:fetch_pkg::offset_bits], {fetch_pkg::offset_bits{1'b0}}};
    end
    if (beat && !response.rlast) begin
      first_word <= response.rdata;
    end
    if (deliver) begin
      // Pick the word that counter bit 2 addresses.
      if (pc[fetch_pkg::offset_bits-1]) begin
        inst <= response.rdata;
      end else begin
        inst <= first_word;
      end
      old_pc <= pc;
    end
  end

endmodule

`default_nettype wire

//--- design/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
  input  logic                    clock,
  input  logic                    reset,

  input  logic                    redirect,
  input  logic [31:0]             redirect_pc,
  input  logic                    npc_valid,
  input  logic [31:0]             snpc,
  input  logic                    flush,

  output logic                    inst_valid,
  output logic [31:0]             inst,
  output logic [31:0]             old_pc,
  input  logic                    idu_ready,
  input  logic                    block,

  output bus_pkg::read_request_t  request,
  input  logic                    arready,
  input  bus_pkg::read_response_t response,
  output logic                    rready
);

  logic [31:0]            pc;
  fetch_pkg::lookup_t     lookup;
  logic                   fill_valid;
  logic [31:0]            fill_addr;
  fetch_pkg::cache_line_t fill_line;

  fetch_control control (
    .clock       (clock),
    .reset       (reset),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .npc_valid   (npc_valid),
    .snpc        (snpc),
    .pc          (pc),
    .lookup      (lookup),
    .fill_valid  (fill_valid),
    .fill_addr   (fill_addr),
    .fill_line   (fill_line),
    .inst_valid  (inst_valid),
    .inst        (inst),
    .old_pc      (old_pc),
    .idu_ready   (idu_ready),
    .block       (block),
    .request     (request),
    .arready     (arready),
    .response    (response),
    .rready      (rready)
  );

  icache_store store (
    .clock      (clock),
    .reset      (reset),
    .pc         (pc),
    .lookup     (lookup),
    .fill_valid (fill_valid),
    .fill_addr  (fill_addr),
    .fill_line  (fill_line),
    .flush      (flush)
  );

endmodule

`default_nettype wire

//--- bench/fetch_memory.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_memory (
  input  logic                    clock,
  input  logic                    reset,
  input  bus_pkg::read_request_t  request,
  output logic                    arready,
  output bus_pkg::read_response_t response,
  input  logic                    rready
);

  localparam logic [31:0] word_mask = 32'h5a5a_5a5a;

  typedef enum logic [2:0] {
    mem_idle,
    address_delay,
    address_take,
    data_delay,
    beat_low,
    beat_high
  } memory_state_e;

  memory_state_e state;
  logic [31:0]   rand_state;
  logic [31:0]   drawn;
  logic [1:0]    delay;
  logic [31:0]   line_address;

  function automatic logic [31:0] next_random(input logic [31:0] value);
    logic [31:0] x;
    x = value;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Memory contents are a fixed function of the address.
  function automatic logic [31:0] word_at(input logic [31:0] address);
    return address ^ word_mask;
  endfunction

  assign drawn = next_random(rand_state);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= mem_idle;
      rand_state <= 32'd20;
      delay <= 2'd0;
      arready <= 1'b0;
      response <= '0;
      line_address <= '0;
    end else begin
      case (state)
        mem_idle: begin
          if (request.arvalid) begin
            delay <= drawn[1:0]; // 0 to 3 cycles before arready.
            rand_state <= drawn;
            state <= address_delay;
          end
        end
        address_delay: begin
          if (delay == 2'd0) begin
            arready <= 1'b1;
            state <= address_take;
          end else begin
            delay <= delay - 2'd1;
          end
        end
        address_take: begin
          arready <= 1'b0; // Address accepted at this edge.
          line_address <= request.araddr;
          delay <= drawn[1:0];
          rand_state <= drawn;
          state <= data_delay;
        end
        data_delay: begin
          if (delay == 2'd0) begin
            response.rvalid <= 1'b1;
            response.rlast <= 1'b0;
            response.rresp <= bus_pkg::okay;
            response.rdata <= word_at(line_address);
            state <= beat_low;
          end else begin
            delay <= delay - 2'd1;
          end
        end
        beat_low: begin
          if (rready) begin
            response.rlast <= 1'b1;
            response.rdata <= word_at(line_address + 32'd4);
            state <= beat_high;
          end
        end
        beat_high: begin
          if (rready) begin
            response <= '0;
            state <= mem_idle;
          end
        end
        default: begin
          state <= mem_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- bench/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

  localparam int field_count = 11; // Code, argument, bursts, eight words.
  localparam int step_limit = 32;
  localparam int cycle_limit = 64; // Per instruction.

  localparam logic [31:0] op_redirect = 32'h1;
  localparam logic [31:0] op_consume = 32'h2;
  localparam logic [31:0] op_stall = 32'h3;
  localparam logic [31:0] op_flush = 32'h4;
  localparam logic [31:0] op_end = 32'h5;

  logic                    clock;
  logic                    reset;
  logic                    redirect;
  logic [31:0]             redirect_pc;
  logic                    npc_valid;
  logic [31:0]             snpc;
  logic                    flush;
  logic                    inst_valid;
  logic [31:0]             inst;
  logic [31:0]             old_pc;
  logic                    idu_ready;
  logic                    block;
  bus_pkg::read_request_t  request;
  logic                    arready;
  bus_pkg::read_response_t response;
  logic                    rready;

  logic [31:0] golden [field_count * step_limit];
  logic [31:0] expect_pc; // Decode's view of the next counter.
  int          burst_count;
  int          step;
  int          base;
  logic        finished;

  fetch_top DUT (
    .clock       (clock),
    .reset       (reset),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .npc_valid   (npc_valid),
    .snpc        (snpc),
    .flush       (flush),
    .inst_valid  (inst_valid),
    .inst        (inst),
    .old_pc      (old_pc),
    .idu_ready   (idu_ready),
    .block       (block),
    .request     (request),
    .arready     (arready),
    .response    (response),
    .rready      (rready)
  );

  fetch_memory memory (
    .clock    (clock),
    .reset    (reset),
    .request  (request),
    .arready  (arready),
    .response (response),
    .rready   (rready)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // One burst per accepted address.
  always @(posedge clock) begin
    if (reset) begin
      burst_count <= 0;
    end else if (request.arvalid && arready) begin
      burst_count <= burst_count + 1;
      // The burst fetches the line that holds the counter decode waits for.
      check_value("araddr", request.araddr, {expect_pc[31:3], 3'b000});
    end
  end

  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  task automatic abort_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Fail at time %0d ns: %s is %h, expected %h", $time, name, actual, expected);
      abort_run();
    end
  endtask

  task automatic send_redirect(input logic [31:0] target);
    redirect = 1'b1;
    redirect_pc = target;
    next_cycle();
    redirect = 1'b0;
    expect_pc = target;
  endtask

  task automatic send_flush();
    flush = 1'b1;
    next_cycle();
    flush = 1'b0;
  endtask

  // Alternate idu_ready low and block high; nothing may move.
  task automatic hold_decode(input int cycles);
    logic [31:0] held_inst;
    logic [31:0] held_pc;
    logic        held_valid;
    int          bursts_before;
    int          i;
    held_inst = inst;
    held_pc = old_pc;
    held_valid = inst_valid;
    bursts_before = burst_count;
    for (i = 0; i < cycles; i++) begin
      idu_ready = i[0];
      block = i[0];
      next_cycle();
      check_value("inst", inst, held_inst);
      check_value("old_pc", old_pc, held_pc);
      check_value("inst_valid", inst_valid, held_valid);
      check_value("burst count", burst_count - bursts_before, 0);
    end
    idu_ready = 1'b0;
    block = 1'b0;
  endtask

  task automatic consume_words(input int record);
    int total;
    int taken;
    int waited;
    int bursts_before;
    total = golden[record + 1];
    taken = 0;
    waited = 0;
    bursts_before = burst_count;
    idu_ready = 1'b1;
    block = 1'b0;
    npc_valid = 1'b1;
    snpc = expect_pc;
    while (taken < total) begin
      if (inst_valid) begin
        // This word is taken at the coming edge.
        check_value("inst", inst, golden[record + 3 + taken]);
        check_value("old_pc", old_pc, expect_pc);
        taken++;
        expect_pc = expect_pc + 32'd4;
        waited = 0;
      end else if (waited == cycle_limit) begin
        $display("Timeout: no instruction from the fetch stage for %0d cycles", cycle_limit);
        abort_run();
      end
      npc_valid = (taken < total); // No sequential permit past the last word.
      snpc = expect_pc;
      waited++;
      next_cycle();
    end
    idu_ready = 1'b0;
    npc_valid = 1'b0;
    check_value("burst count", burst_count - bursts_before, golden[record + 2]);
  endtask

  initial begin
    reset = 1'b1;
    redirect = 1'b0;
    redirect_pc = 32'd0;
    npc_valid = 1'b0;
    snpc = 32'd0;
    flush = 1'b0;
    idu_ready = 1'b0;
    block = 1'b0;
    expect_pc = 32'h3000_0000; // Boot address.
    finished = 1'b0;
    $readmemh("bench/fetch_golden.txt", golden);
    repeat (16) @(posedge clock);
    #1;
    reset = 1'b0;
    check_value("inst_valid", inst_valid, 1'b0);
    check_value("arvalid", request.arvalid, 1'b0);
    check_value("rready", rready, 1'b0);
    for (step = 0; step < step_limit && !finished; step++) begin
      base = step * field_count;
      case (golden[base])
        op_redirect: send_redirect(golden[base + 1]);
        op_consume: consume_words(base);
        op_stall: hold_decode(golden[base + 1]);
        op_flush: send_flush();
        op_end: finished = 1'b1;
        default: begin
          $display("Golden file step %0d has an unknown operation code %h", step, golden[base]);
          abort_run();
        end
      endcase
    end
    if (finished) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("Golden file ends without an end step");
      abort_run();
    end
  end

endmodule

`default_nettype wire

//--- bench/fetch_golden.txt
// code arg bursts w0 w1 w2 w3 w4 w5 w6 w7 (hex); 1 redirect, 2 consume, 3 stall, 4 flush, 5 end
// arg is a redirect address or a count; bursts are the new bursts of a consume step
// Boot and sequential fetch
2 8 4 6a5a5a5a 6a5a5a5e 6a5a5a52 6a5a5a56 6a5a5a4a 6a5a5a4e 6a5a5a42 6a5a5a46
// Hit path
1 30000000 0 0 0 0 0 0 0 0 0
2 8 0 6a5a5a5a 6a5a5a5e 6a5a5a52 6a5a5a56 6a5a5a4a 6a5a5a4e 6a5a5a42 6a5a5a46
// Uncached SRAM goes to the bus for every word, twice
1 0f000000 0 0 0 0 0 0 0 0 0
2 4 4 555a5a5a 555a5a5e 555a5a52 555a5a56 0 0 0 0
1 0f000000 0 0 0 0 0 0 0 0 0
2 4 4 555a5a5a 555a5a5e 555a5a52 555a5a56 0 0 0 0
// Flush
4 0 0 0 0 0 0 0 0 0 0
1 30000000 0 0 0 0 0 0 0 0 0
2 4 2 6a5a5a5a 6a5a5a5e 6a5a5a52 6a5a5a56 0 0 0 0
// Back-pressure with no instruction held
3 5 0 0 0 0 0 0 0 0 0
2 4 2 6a5a5a4a 6a5a5a4e 6a5a5a42 6a5a5a46 0 0 0 0
// Back-pressure with a hit held
1 30000000 0 0 0 0 0 0 0 0 0
2 3 0 6a5a5a5a 6a5a5a5e 6a5a5a52 0 0 0 0 0
3 6 0 0 0 0 0 0 0 0 0
2 3 0 6a5a5a56 6a5a5a4a 6a5a5a4e 0 0 0 0 0
// Redirect mid-line
1 30000004 0 0 0 0 0 0 0 0 0
2 2 0 6a5a5a5e 6a5a5a52 0 0 0 0 0 0
// Conflict on index 0 and back
1 30000080 0 0 0 0 0 0 0 0 0
2 2 1 6a5a5ada 6a5a5ade 0 0 0 0 0 0
1 30000000 0 0 0 0 0 0 0 0 0
2 2 1 6a5a5a5a 6a5a5a5e 0 0 0 0 0 0
5 0 0 0 0 0 0 0 0 0 0

//--- sim.f
design/fetch_pkg.sv
design/bus_pkg.sv
design/icache_store.sv
design/fetch_control.sv
design/fetch_top.sv
bench/fetch_memory.sv
bench/fetch_tb.sv
